//--- hdl/dla_pkg.sv
// shared widths, opcodes and bundles for the dot-product engine, imported by every RTL block

package dla_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int BYTE_W       = 8;
    localparam int REGION_BYTES = 256;
    // top address bit selects data (0) or weight (1)
    localparam int ADDR_W       = 9;
    // lengths run from 1 to 256
    localparam int LEN_W        = 9;
    localparam int MAX_WR_BYTES = 20;
    localparam int RESULT_W     = 32;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    // number of 4-byte words to store, other codes store nothing
    typedef enum logic [2:0] {
        W4  = 3'd1,
        W8  = 3'd2,
        W12 = 3'd3,
        W16 = 3'd4,
        W20 = 3'd5
    } wsize_e;

    // window slide of 3 or 5 rows of 4 bytes
    typedef enum logic [2:0] {
        K3 = 3'd3,
        K5 = 3'd5
    } kernel_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } ctrl_state_e;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    // byte k of data sits in bits 8k+7 .. 8k
    typedef struct packed {
        logic [ADDR_W-1:0]              addr;
        wsize_e                         wsize;
        logic [MAX_WR_BYTES*BYTE_W-1:0] data;
    } wr_req_t;

    typedef struct packed {
        logic signed [BYTE_W-1:0] data;
        logic signed [BYTE_W-1:0] weight;
    } byte_pair_t;

endpackage

//--- hdl/dla_buffer.sv
// operand byte buffer: data and weight regions with a write port, window shift and pair read
`timescale 1ns/10ps

module dla_buffer
    import dla_pkg::*;
#(
    parameter int REGION_BYTES = dla_pkg::REGION_BYTES
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             busy,
    input  logic             wr_valid,
    input  wr_req_t          wr,
    input  logic             shift_valid,
    input  kernel_e          shift_kernel,
    input  logic [LEN_W-2:0] idx,
    output byte_pair_t       pair
);

    localparam int TOTAL_BYTES = 2 * REGION_BYTES;

    // data bytes in the lower half, weights in the upper half
    logic [BYTE_W-1:0] mem [TOTAL_BYTES];

    logic [4:0] wr_bytes;
    logic [4:0] shift_bytes;
    logic       wr_en;
    logic       shift_en;

    // --------------------------------------------------
    // opcode decode
    // --------------------------------------------------
    always_comb begin
        case (wr.wsize)
            W4:      wr_bytes = 5'd4;
            W8:      wr_bytes = 5'd8;
            W12:     wr_bytes = 5'd12;
            W16:     wr_bytes = 5'd16;
            W20:     wr_bytes = 5'd20;
            default: wr_bytes = 5'd0;
        endcase
    end

    always_comb begin
        case (shift_kernel)
            K3:      shift_bytes = 5'd12;
            K5:      shift_bytes = 5'd20;
            default: shift_bytes = 5'd0;
        endcase
    end

    // a compute in flight locks the buffer
    assign wr_en    = wr_valid && !busy;
    // a write wins over a shift in the same cycle
    assign shift_en = shift_valid && !wr_valid && !busy;

    // --------------------------------------------------
    // write and shift
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TOTAL_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            // bytes past the top of the buffer are dropped
            for (int k = 0; k < MAX_WR_BYTES; k++) begin
                if (k < int'(wr_bytes) && int'(wr.addr) + k < TOTAL_BYTES) begin
                    mem[int'(wr.addr) + k] <= wr.data[k*BYTE_W +: BYTE_W];
                end
            end
        end else if (shift_en && shift_bytes != 5'd0) begin
            // source index stays inside the array since the weight region follows
            for (int i = 0; i < REGION_BYTES; i++) begin
                if (i + int'(shift_bytes) < REGION_BYTES) begin
                    mem[i] <= mem[i + int'(shift_bytes)];
                end else begin
                    mem[i] <= '0;
                end
            end
        end
    end

    // --------------------------------------------------
    // pair read
    // --------------------------------------------------
    // combinational, idx is bounded by the counter to the region size
    assign pair.data   = mem[int'(idx)];
    assign pair.weight = mem[REGION_BYTES + int'(idx)];

endmodule

//--- hdl/dla_ctrl.sv
// compute sequencer: accepts a request in idle and holds run until the last byte pair
`timescale 1ns/10ps

module dla_ctrl
    import dla_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             dla_req,
    input  logic [LEN_W-1:0] len,
    input  logic             last,
    output logic             start,
    output logic             busy,
    output logic             mac_valid
);

    ctrl_state_e state;
    ctrl_state_e state_next;

    // zero length requests are dropped
    assign start = (state == IDLE) && dla_req && (len != '0);

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    // one byte pair reaches the MAC on every run cycle
    assign busy      = (state == RUN);
    assign mac_valid = (state == RUN);

endmodule

//--- hdl/dla_index_counter.sv
// byte index counter for the dot product, loaded on start and flagging the final index
`timescale 1ns/10ps

module dla_index_counter
    import dla_pkg::*;
#(
    parameter int REGION_BYTES = dla_pkg::REGION_BYTES
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [LEN_W-1:0] len,
    output logic [LEN_W-2:0] idx,
    output logic             last
);

    localparam logic [LEN_W-2:0] MAX_IDX = (LEN_W-1)'(REGION_BYTES - 1);

    logic [LEN_W-1:0] len_m1;
    logic [LEN_W-2:0] bound_next;
    logic [LEN_W-2:0] bound;

    // clamp to the region so reads never leave it
    assign len_m1     = len - 1'b1;
    assign bound_next = (len_m1 > LEN_W'(MAX_IDX)) ? MAX_IDX : len_m1[LEN_W-2:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            bound <= '0;
        end else if (start) begin
            idx   <= '0;
            bound <= bound_next;
        end else if (idx != bound) begin
            idx <= idx + 1'b1;
        end
    end

    assign last = (idx == bound);

endmodule

//--- hdl/dla_mac.sv
// signed int8 multiply-accumulate, one byte pair per cycle, with a registered result
`timescale 1ns/10ps

module dla_mac
    import dla_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mac_valid,
    input  logic                last,
    input  byte_pair_t          pair,
    output logic [RESULT_W-1:0] result,
    output logic                res_vld
);

    logic signed [2*BYTE_W-1:0] product;
    logic signed [RESULT_W-1:0] product_ext;
    logic signed [RESULT_W-1:0] acc;
    logic signed [RESULT_W-1:0] acc_next;
    logic                       first;

    assign product     = $signed(pair.data) * $signed(pair.weight);
    assign product_ext = {{(RESULT_W-2*BYTE_W){product[2*BYTE_W-1]}}, product};

    // first product of a run replaces the old sum
    assign acc_next = (first ? '0 : acc) + product_ext;

    // --------------------------------------------------
    // accumulator
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (mac_valid) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first <= 1'b1;
        end else if (mac_valid) begin
            first <= last;
        end
    end

    // --------------------------------------------------
    // result
    // --------------------------------------------------
    // result holds until the next completed run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result  <= '0;
            res_vld <= 1'b0;
        end else begin
            res_vld <= mac_valid && last;
            if (mac_valid && last) begin
                result <= acc_next;
            end
        end
    end

endmodule

//--- hdl/dla_top.sv
// top level of the dot-product engine, connecting buffer, sequencer, index counter and MAC
`timescale 1ns/10ps

module dla_top
    import dla_pkg::*;
#(
    parameter int REGION_BYTES = dla_pkg::REGION_BYTES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_valid,
    input  wr_req_t             wr,
    input  logic                shift_valid,
    input  kernel_e             shift_kernel,
    input  logic                dla_req,
    input  logic [LEN_W-1:0]    len,
    output logic [RESULT_W-1:0] result,
    output logic                res_vld
);

    logic             busy;
    logic             start;
    logic             mac_valid;
    logic [LEN_W-2:0] idx;
    logic             last;
    byte_pair_t       pair;

    // --------------------------------------------------
    // operand storage
    // --------------------------------------------------
    dla_buffer #(
        .REGION_BYTES (REGION_BYTES)
    ) u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy         (busy),
        .wr_valid     (wr_valid),
        .wr           (wr),
        .shift_valid  (shift_valid),
        .shift_kernel (shift_kernel),
        .idx          (idx),
        .pair         (pair)
    );

    // --------------------------------------------------
    // sequencing
    // --------------------------------------------------
    dla_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .dla_req   (dla_req),
        .len       (len),
        .last      (last),
        .start     (start),
        .busy      (busy),
        .mac_valid (mac_valid)
    );

    dla_index_counter #(
        .REGION_BYTES (REGION_BYTES)
    ) u_index_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .len   (len),
        .idx   (idx),
        .last  (last)
    );

    // --------------------------------------------------
    // arithmetic
    // --------------------------------------------------
    dla_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_valid (mac_valid),
        .last      (last),
        .pair      (pair),
        .result    (result),
        .res_vld   (res_vld)
    );

endmodule

//--- bench/dla_tb_tasks.svh
// stimulus tasks and random byte source, included inside the dot-product testbench module
`ifndef DLA_TB_TASKS_SVH
`define DLA_TB_TASKS_SVH

logic [31:0] lfsr_state = 32'h325c69b1;

// galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h80200003 : 32'h0);
    return b;
endfunction

function automatic logic [7:0] random_byte();
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
        v[i] = next_bit();
    end
    return v;
endfunction

// --------------------------------------------------
// buffer traffic
// --------------------------------------------------
task automatic write_word(input logic [ADDR_W-1:0] addr, input wsize_e ws,
                          input logic [MAX_WR_BYTES*BYTE_W-1:0] data);
    @(negedge clk);
    wr_valid = 1'b1;
    wr.addr  = addr;
    wr.wsize = ws;
    wr.data  = data;
    @(negedge clk);
    wr_valid = 1'b0;
endtask

task automatic write_random(input logic [ADDR_W-1:0] addr, input wsize_e ws);
    logic [MAX_WR_BYTES*BYTE_W-1:0] data;
    for (int k = 0; k < MAX_WR_BYTES; k++) begin
        data[k*BYTE_W +: BYTE_W] = random_byte();
    end
    write_word(addr, ws, data);
endtask

// sweep both regions, cycling through every write size
task automatic fill_buffer();
    int addr;
    int code;
    addr = 0;
    code = 1;
    while (addr < 2 * REGION_BYTES) begin
        write_random(ADDR_W'(addr), wsize_e'(code));
        addr += 4 * code;
        code = (code == 5) ? 1 : code + 1;
    end
endtask

task automatic shift_window(input kernel_e k);
    @(negedge clk);
    shift_valid  = 1'b1;
    shift_kernel = k;
    @(negedge clk);
    shift_valid = 1'b0;
endtask

// --------------------------------------------------
// compute requests
// --------------------------------------------------
task automatic request(input logic [LEN_W-1:0] n);
    @(negedge clk);
    dla_req = 1'b1;
    len     = n;
    @(negedge clk);
    dla_req = 1'b0;
endtask

task automatic wait_result(input logic [LEN_W-1:0] n);
    int waited;
    waited = 0;
    while (!res_vld && waited < int'(n) + 16) begin
        @(negedge clk);
        waited++;
    end
    if (!res_vld) begin
        report_failure($sformatf("no res_vld within %0d cycles in %s", waited, test_name));
    end
    @(negedge clk);
endtask

task automatic run_compute(input logic [LEN_W-1:0] n);
    request(n);
    wait_result(n);
endtask

// write, shift and a second request all land while the engine runs
task automatic run_compute_with_traffic(input logic [LEN_W-1:0] n);
    request(n);
    write_random(9'd0, W20);
    shift_window(K5);
    request(9'd7);
    wait_result(n);
endtask

`endif

//--- bench/dla_tb.sv
// testbench top for the dot-product engine that holds the byte model and the checks on dla_top
`timescale 1ns/10ps

module dla_tb
    import dla_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    // compute lengths of the test flow in order
    localparam int LEN_SUM         = 1 + 7 + 256 + 1 + 256 + 256 + 256 + 64 + 256;
    localparam int N_COMPUTES      = 9;
    localparam int N_WRITES        = 2 * REGION_BYTES / 4 + 8;
    localparam int WATCHDOG_CYCLES = 8 + 2 * N_WRITES + LEN_SUM + 20 * N_COMPUTES + 100;

    logic                clk;
    logic                rst_n;
    logic                wr_valid;
    wr_req_t             wr;
    logic                shift_valid;
    kernel_e             shift_kernel;
    logic                dla_req;
    logic [LEN_W-1:0]    len;
    logic [RESULT_W-1:0] result;
    logic                res_vld;

    // byte model of both regions and the expected response
    byte                 model_mem [2*REGION_BYTES];
    int                  remaining;
    int                  pulse_count = 0;
    logic                exp_vld;
    logic [RESULT_W-1:0] exp_result;
    logic                seen_req;
    string               test_name = "reset";

    dla_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr           (wr),
        .shift_valid  (shift_valid),
        .shift_kernel (shift_kernel),
        .dla_req      (dla_req),
        .len          (len),
        .result       (result),
        .res_vld      (res_vld)
    );

    `include "dla_tb_tasks.svh"

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("watchdog expired during %s", test_name));
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int span_of(logic [LEN_W-1:0] n);
        return (int'(n) > REGION_BYTES) ? REGION_BYTES : int'(n);
    endfunction

    function automatic void model_write(wr_req_t w);
        int nbytes;
        nbytes = (int'(w.wsize) >= 1 && int'(w.wsize) <= 5) ? 4 * int'(w.wsize) : 0;
        for (int k = 0; k < nbytes; k++) begin
            if (int'(w.addr) + k < 2 * REGION_BYTES) begin
                model_mem[int'(w.addr) + k] = byte'(w.data[k*BYTE_W +: BYTE_W]);
            end
        end
    endfunction

    function automatic void model_shift(kernel_e k);
        int s;
        case (k)
            K3:      s = 12;
            K5:      s = 20;
            default: s = 0;
        endcase
        // ascending order reads each source before it is overwritten
        for (int i = 0; i < REGION_BYTES && s != 0; i++) begin
            model_mem[i] = (i + s < REGION_BYTES) ? model_mem[i + s] : 8'sd0;
        end
    endfunction

    function automatic int dot_product(int n);
        int acc;
        acc = 0;
        for (int i = 0; i < n; i++) begin
            acc += int'(model_mem[i]) * int'(model_mem[REGION_BYTES + i]);
        end
        return acc;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2 * REGION_BYTES; i++) begin
                model_mem[i] = 8'sd0;
            end
            remaining = 0;
            exp_vld    <= 1'b0;
            exp_result <= '0;
            seen_req   <= 1'b0;
        end else begin
            exp_vld <= 1'b0;
            if (remaining != 0) begin
                // every strobe is ignored while the engine is busy
                remaining = remaining - 1;
                if (remaining == 0) begin
                    exp_vld <= 1'b1;
                end
            end else begin
                if (wr_valid) begin
                    model_write(wr);
                end else if (shift_valid) begin
                    model_shift(shift_kernel);
                end
                if (dla_req && len != '0) begin
                    remaining = span_of(len);
                    exp_result <= RESULT_W'(dot_product(span_of(len)));
                    seen_req   <= 1'b1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && res_vld) begin
            pulse_count++;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    vld_timing: assert property (@(posedge clk) disable iff (!rst_n) res_vld == exp_vld)
        else report_failure($sformatf("mismatch %s res_vld expected %0b actual %0b",
            test_name, $sampled(exp_vld), $sampled(res_vld)));

    result_value: assert property (@(posedge clk) disable iff (!rst_n)
        res_vld |-> result == exp_result)
        else report_failure($sformatf("mismatch %s result expected 0x%08h actual 0x%08h",
            test_name, $sampled(exp_result), $sampled(result)));

    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !res_vld |-> $stable(result))
        else report_failure($sformatf("result changed during %s without a res_vld pulse",
            test_name));

    reset_value: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> result == '0)
        else report_failure($sformatf("mismatch %s result expected 0x%08h actual 0x%08h",
            test_name, 32'h0, $sampled(result)));

    // --------------------------------------------------
    // test flow
    // --------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr           = '0;
        shift_valid  = 1'b0;
        shift_kernel = K3;
        dla_req      = 1'b0;
        len          = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        test_name = "random fill";
        fill_buffer();
        run_compute(9'd1);
        run_compute(9'd7);
        run_compute(9'd256);

        test_name = "min product";
        write_word(9'd0, W4, 160'h80);
        write_word(9'd256, W4, 160'h80);
        run_compute(9'd1);

        test_name = "shift k3";
        shift_window(K3);
        run_compute(9'd256);

        test_name = "shift k5";
        shift_window(K5);
        run_compute(9'd256);

        test_name = "invalid codes";
        shift_window(kernel_e'(3'd2));
        write_random(9'd40, wsize_e'(3'd7));
        run_compute(9'd256);

        test_name = "busy lockout";
        run_compute_with_traffic(9'd64);

        test_name = "top edge write";
        write_random(9'd500, W20);
        run_compute(9'd256);

        repeat (4) @(negedge clk);
        if (pulse_count != N_COMPUTES) begin
            report_failure($sformatf("mismatch %s pulse count expected %0d actual %0d",
                test_name, N_COMPUTES, pulse_count));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+bench
hdl/dla_pkg.sv
hdl/dla_buffer.sv
hdl/dla_ctrl.sv
hdl/dla_index_counter.sv
hdl/dla_mac.sv
hdl/dla_top.sv
bench/dla_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dla_tb \
    -f list.f \
    -o dla_sim

./obj_dir/dla_sim | tee /dev/stderr | grep "Test passed" > /dev/null
